/* sim.f */
+incdir+.
c1s2_pkg.sv
layer_sequencer.sv
window_assembler.sv
coef_rom.sv
conv_mac.sv
pool_writer.sv
c1s2_top.sv
tb_c1s2.sv

/* tb_c1s2.sv */
`include "c1s2_consts.svh"

module tb_c1s2;
    import c1s2_pkg::*;

    localparam int CLK_PERIOD    = 4;
    localparam int IMG_PIX       = `IMG_W * `IMG_W;
    localparam int OUT_NUM       = `KERNEL_NUM * `POOL_W * `POOL_W;  // 96 output words
    localparam int READS_PER_RUN = `ANCHOR_NUM * `WIN_K;
    localparam int RUN_CYCLES    = `ANCHOR_NUM * `ANCHOR_PERIOD + 36;  // pipeline tail and idle gap
    // two runs plus reset and margin
    localparam int WATCHDOG_TIME = (2 * RUN_CYCLES + 160) * CLK_PERIOD;

    logic      clk;
    logic      rst_n;
    logic      en;
    row_t      rd_data;
    logic      rd_en;
    in_addr_t  rd_addr;
    logic      wr_en;
    out_addr_t wr_addr;
    pixel_t    wr_data;
    logic      work_finished;

    pixel_t      img [IMG_PIX];
    logic [15:0] exp_out [OUT_NUM];  // indexed by output address
    bit          written [OUT_NUM];
    int          seed;
    int          rd_cnt;
    int          wr_cnt;
    logic        armed;              // a run has been started and not finished
    logic        wf_prev;
    logic        req_q;
    in_addr_t    addr_q;

    c1s2_top u_c1s2_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .en            (en),
        .rd_data       (rd_data),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .work_finished (work_finished)
    );

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic value_error(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        $display("ERR %s expected %h got %h", name, exp_val, act_val);
        abort_run();
    endtask

    task automatic plain_error(input string what);
        $display("%s", what);
        abort_run();
    endtask

    // pixels 0..15 keep every sum well inside 16 bits
    task automatic fill_image();
        for (int i = 0; i < IMG_PIX; i++)
            img[i] = pixel_t'($random(seed) & 15);
    endtask

    // relu of one kernel at one anchor
    function automatic int conv_ref(input int k, input int ay, input int ax);
        int sum;
        int t;
        sum = 4 * k - 10;
        for (int r = 0; r < `WIN_K; r++)
        begin
            for (int c = 0; c < `WIN_K; c++)
            begin
                t = r * `WIN_K + c;
                sum += (((k + t) % 3) - 1) * int'(img[(ay + r) * `IMG_W + ax + c]);
            end
        end
        return (sum < 0) ? 0 : sum;
    endfunction

    task automatic compute_model();
        int best;
        int v;
        int ay;
        int ax;
        for (int k = 0; k < `KERNEL_NUM; k++)
        begin
            for (int p = 0; p < `POOL_W * `POOL_W; p++)
            begin
                best = 0;
                for (int s = 0; s < 4; s++)
                begin
                    ay = 2 * (p / `POOL_W) + s / 2;
                    ax = 2 * (p % `POOL_W) + s % 2;
                    v  = conv_ref(k, ay, ax);
                    if (v > best)
                        best = v;
                end
                exp_out[k * `OUT_KERNEL_OFFSET + p] = best[15:0];
            end
        end
    endtask

    // n-th row read of a run with anchors in pooling order
    function automatic int read_addr_ref(input int n);
        int a;
        int pool;
        int sub;
        a    = n / `WIN_K;
        pool = a / 4;
        sub  = a % 4;
        return (2 * (pool / `POOL_W) + sub / 2 + n % `WIN_K) * `IMG_W
               + 2 * (pool % `POOL_W) + sub % 2;
    endfunction

    task automatic run_layer();
        @(posedge clk);
        #1;
        rd_cnt = 0;
        wr_cnt = 0;
        for (int i = 0; i < OUT_NUM; i++)
            written[i] = 1'b0;
        armed = 1'b1;
        en    = 1'b1;  // held through the run, sampled only in idle
        @(negedge clk);
        while (!work_finished)
            @(negedge clk);
        @(posedge clk);
        #1 en = 1'b0;
        repeat (20) @(posedge clk);  // quiet gap before the next start
    endtask

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // image memory answers one cycle after rd_en
    always @(posedge clk)
    begin
        #1;
        for (int i = 0; i < `WIN_K; i++)
        begin
            if (req_q && int'(addr_q) + i < IMG_PIX)
                rd_data[i] = img[int'(addr_q) + i];
            else
                rd_data[i] = '0;
        end
    end

    always @(negedge clk)
    begin
        req_q  = rd_en;
        addr_q = rd_addr;
        if (!rst_n)
        begin
            assert (!rd_en && !wr_en && !work_finished)
                else plain_error("outputs active during reset");
        end
        else
        begin
            if (rd_en)
            begin
                assert (armed) else plain_error("row read issued while the layer was idle");
                assert (rd_cnt < READS_PER_RUN) else plain_error("more row reads than one image");
                assert (int'(rd_addr) < IMG_PIX - 4 && int'(rd_addr) % `IMG_W <= `IMG_W - 5)
                    else plain_error("row read outside the image");
                assert (int'(rd_addr) == read_addr_ref(rd_cnt))
                    else value_error("rd_addr", read_addr_ref(rd_cnt), rd_addr);
                rd_cnt++;
            end
            if (wr_en)
            begin
                assert (armed) else plain_error("write issued while the layer was idle");
                assert (int'(wr_addr) < OUT_NUM) else plain_error("write outside the output map");
                assert (!written[wr_addr]) else plain_error("output address written twice");
                assert (wr_data == exp_out[wr_addr])
                    else value_error("wr_data", exp_out[wr_addr], wr_data);
                written[wr_addr] = 1'b1;
                wr_cnt++;
            end
            if (work_finished)
            begin
                assert (!wf_prev) else plain_error("work_finished longer than one cycle");
                assert (armed) else plain_error("work_finished without a started run");
                assert (wr_cnt == OUT_NUM) else plain_error("work_finished before the last write");
                assert (rd_cnt == READS_PER_RUN) else plain_error("run ended with reads missing");
                armed = 1'b0;
            end
            wf_prev = work_finished;
        end
    end

    initial
    begin
        #(WATCHDOG_TIME);
        plain_error("layer never finished before the watchdog expired");
    end

    initial
    begin
        seed    = 88;
        rst_n   = 1'b0;
        en      = 1'b0;
        rd_data = '0;
        armed   = 1'b0;
        wf_prev = 1'b0;
        req_q   = 1'b0;
        addr_q  = '0;
        rd_cnt  = 0;
        wr_cnt  = 0;
        fill_image();
        compute_model();
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        repeat (4) @(posedge clk);  // idle cycles after reset
        run_layer();
        fill_image();  // fresh image for the second run
        compute_model();
        run_layer();
        $display("Test OK");
        $finish;
    end

endmodule

/* c1s2_top.sv */
module c1s2_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                en,
    input  c1s2_pkg::row_t      rd_data,
    output logic                rd_en,
    output c1s2_pkg::in_addr_t  rd_addr,
    output logic                wr_en,
    output c1s2_pkg::out_addr_t wr_addr,
    output c1s2_pkg::pixel_t    wr_data,
    output logic                work_finished
);
    import c1s2_pkg::*;

    logic    layer_done;
    logic    win_valid;
    window_t window;
    kidx_t   coef_kidx;
    window_t weights;
    pixel_t  bias;
    logic    res_valid;
    kidx_t   res_kidx;
    pixel_t  res_value;

    layer_sequencer u_layer_sequencer (
        .clk           (clk),
        .rst_n         (rst_n),
        .en            (en),
        .layer_done    (layer_done),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .work_finished (work_finished)
    );

    window_assembler u_window_assembler (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_en     (rd_en),
        .rd_data   (rd_data),
        .win_valid (win_valid),
        .window    (window)
    );

    coef_rom u_coef_rom (
        .clk     (clk),
        .kidx    (coef_kidx),
        .weights (weights),
        .bias    (bias)
    );

    conv_mac u_conv_mac (
        .clk       (clk),
        .rst_n     (rst_n),
        .win_valid (win_valid),
        .window    (window),
        .weights   (weights),
        .bias      (bias),
        .coef_kidx (coef_kidx),
        .res_valid (res_valid),
        .res_kidx  (res_kidx),
        .res_value (res_value)
    );

    pool_writer u_pool_writer (
        .clk        (clk),
        .rst_n      (rst_n),
        .res_valid  (res_valid),
        .res_kidx   (res_kidx),
        .res_value  (res_value),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .layer_done (layer_done)
    );

endmodule

/* pool_writer.sv */
`include "c1s2_consts.svh"

module pool_writer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                res_valid,
    input  c1s2_pkg::kidx_t     res_kidx,
    input  c1s2_pkg::pixel_t    res_value,
    output logic                wr_en,
    output c1s2_pkg::out_addr_t wr_addr,
    output c1s2_pkg::pixel_t    wr_data,
    output logic                layer_done
);
    import c1s2_pkg::*;

    pixel_t     pool_max [`KERNEL_NUM];  // running max per kernel
    logic [1:0] sub_cnt;                 // anchor within the 2x2 group
    logic [3:0] pool_idx;
    pixel_t     new_max;
    logic       last_kernel;

    assign new_max = (res_value > pool_max[res_kidx]) ? res_value : pool_max[res_kidx];
    assign last_kernel = (res_kidx == kidx_t'(`KERNEL_NUM - 1));

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int k = 0; k < `KERNEL_NUM; k++)
                pool_max[k] <= '0;
            sub_cnt    <= '0;
            pool_idx   <= '0;
            wr_en      <= 1'b0;
            layer_done <= 1'b0;
        end
        else
        begin
            wr_en      <= 1'b0;
            layer_done <= 1'b0;
            if (res_valid)
            begin
                if (sub_cnt == 2'd3)
                begin
                    pool_max[res_kidx] <= '0;  // relu results start from zero
                    wr_en      <= 1'b1;
                    layer_done <= last_kernel && (pool_idx == 4'(`POOL_W * `POOL_W - 1));
                end
                else
                    pool_max[res_kidx] <= new_max;
                if (last_kernel)
                begin
                    sub_cnt <= sub_cnt + 2'd1;
                    if (sub_cnt == 2'd3)
                        pool_idx <= pool_idx + 4'd1;  // wraps for the next image
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (res_valid && sub_cnt == 2'd3)
        begin
            wr_data <= new_max;
            wr_addr <= out_addr_t'(res_kidx * `OUT_KERNEL_OFFSET + pool_idx);
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> wr_addr < out_addr_t'(`KERNEL_NUM * `OUT_KERNEL_OFFSET));

endmodule

/* conv_mac.sv */
`include "c1s2_consts.svh"

module conv_mac (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              win_valid,
    input  c1s2_pkg::window_t window,
    input  c1s2_pkg::window_t weights,
    input  c1s2_pkg::pixel_t  bias,
    output c1s2_pkg::kidx_t   coef_kidx,
    output logic              res_valid,
    output c1s2_pkg::kidx_t   res_kidx,
    output c1s2_pkg::pixel_t  res_value
);
    import c1s2_pkg::*;

    localparam int PROD_W = 2 * `PIX_W;
    localparam int SUM_W  = PROD_W + 6;  // 25 products plus bias

    logic                     issue_run;   // kernels 1..5 still to go
    kidx_t                    issue_kidx;
    logic                     issue_v;
    window_t                  win_q;       // held while all six kernels use it
    logic                     v1;
    logic                     v2;
    logic                     v3;
    kidx_t                    k1;
    kidx_t                    k2;
    kidx_t                    k3;
    pixel_t                   bias2;
    pixel_t                   bias3;
    logic signed [PROD_W-1:0] prod [`WIN_TAPS];
    logic signed [SUM_W-1:0]  tree_sum;
    logic signed [SUM_W-1:0]  acc;
    logic signed [SUM_W-1:0]  biased;

    assign issue_v   = win_valid | issue_run;
    assign coef_kidx = win_valid ? kidx_t'(0) : issue_kidx;  // kernel 0 with the strobe

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            issue_run  <= 1'b0;
            issue_kidx <= '0;
            v1         <= 1'b0;
            v2         <= 1'b0;
            v3         <= 1'b0;
            res_valid  <= 1'b0;
        end
        else
        begin
            if (win_valid)
            begin
                issue_run  <= 1'b1;
                issue_kidx <= kidx_t'(1);
            end
            else if (issue_run)
            begin
                if (issue_kidx == kidx_t'(`KERNEL_NUM - 1))
                    issue_run <= 1'b0;
                issue_kidx <= issue_kidx + kidx_t'(1);
            end
            v1        <= issue_v;  // rom stage
            v2        <= v1;       // products
            v3        <= v2;       // adder tree
            res_valid <= v3;       // bias and relu
        end
    end

    always_comb
    begin
        tree_sum = '0;
        for (int t = 0; t < `WIN_TAPS; t++)
            tree_sum = tree_sum + prod[t];
    end

    assign biased = acc + bias3;

    always_ff @(posedge clk)
    begin
        if (win_valid)
            win_q <= window;
        k1 <= coef_kidx;
        for (int t = 0; t < `WIN_TAPS; t++)
            prod[t] <= win_q[t] * weights[t];
        k2       <= k1;
        bias2    <= bias;
        acc      <= tree_sum;
        k3       <= k2;
        bias3    <= bias2;
        res_kidx <= k3;
        res_value <= (biased < 0) ? '0 : pixel_t'(biased);  // relu, then keep low word
    end

    // a positive sum that wraps in 16 bits would show up here
    assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> !res_value[`PIX_W-1]);

endmodule

/* coef_rom.sv */
`include "c1s2_consts.svh"

module coef_rom (
    input  logic              clk,
    input  c1s2_pkg::kidx_t   kidx,
    output c1s2_pkg::window_t weights,
    output c1s2_pkg::pixel_t  bias
);
    import c1s2_pkg::*;

    window_t kern_tab [`KERNEL_NUM];
    pixel_t  bias_tab [`KERNEL_NUM];

    // weight of kernel k, tap t is ((k + t) mod 3) - 1
    // bias of kernel k is 4k - 10
    always_comb
    begin
        for (int k = 0; k < `KERNEL_NUM; k++)
        begin
            bias_tab[k] = pixel_t'(4 * k - 10);
            for (int t = 0; t < `WIN_TAPS; t++)
                kern_tab[k][t] = pixel_t'((k + t) % 3 - 1);
        end
    end

    // one cycle read latency
    always_ff @(posedge clk)
    begin
        if (kidx < kidx_t'(`KERNEL_NUM))
        begin
            weights <= kern_tab[kidx];
            bias    <= bias_tab[kidx];
        end
        else
        begin
            weights <= '0;
            bias    <= '0;
        end
    end

endmodule

/* window_assembler.sv */
`include "c1s2_consts.svh"

module window_assembler (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              rd_en,
    input  c1s2_pkg::row_t    rd_data,
    output logic              win_valid,
    output c1s2_pkg::window_t window
);
    import c1s2_pkg::*;

    row_t       win_buf [2][`WIN_K];
    logic       data_valid;  // memory answers one cycle after rd_en
    logic [2:0] row_cnt;
    logic       show_sel;    // presented buffer, the other one fills

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            data_valid <= 1'b0;
            row_cnt    <= '0;
            show_sel   <= 1'b0;
            win_valid  <= 1'b0;
        end
        else
        begin
            data_valid <= rd_en;
            win_valid  <= 1'b0;
            if (data_valid)
            begin
                if (row_cnt == 3'(`WIN_K - 1))
                begin
                    // last row lands this edge, present it
                    row_cnt   <= '0;
                    show_sel  <= ~show_sel;
                    win_valid <= 1'b1;
                end
                else
                    row_cnt <= row_cnt + 3'd1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (data_valid)
            win_buf[~show_sel][row_cnt] <= rd_data;
    end

    always_comb
    begin
        for (int r = 0; r < `WIN_K; r++)
        begin
            for (int c = 0; c < `WIN_K; c++)
                window[r * `WIN_K + c] = win_buf[show_sel][r][c];
        end
    end

    // conv_mac needs a full anchor period per window
    assert property (@(posedge clk) disable iff (!rst_n)
        win_valid |=> !win_valid [*(`ANCHOR_PERIOD - 1)]);

endmodule

/* layer_sequencer.sv */
`include "c1s2_consts.svh"

module layer_sequencer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               en,
    input  logic               layer_done,
    output logic               rd_en,
    output c1s2_pkg::in_addr_t rd_addr,
    output logic               work_finished
);
    import c1s2_pkg::*;

    typedef enum logic [1:0] {st_idle, st_running, st_stall, st_finished} state_t;

    state_t     state;
    logic [2:0] phase;        // 0..4 row reads, 5 is the gap
    logic [5:0] anchor;
    logic [5:0] anchor_nxt;

    // row 0 address of anchor a, anchors walked in pooling order
    function automatic in_addr_t anchor_base(input logic [5:0] a);
        logic [2:0] ay;
        logic [2:0] ax;
        ay = {a[5:4], a[1]};  // 2*pool_y + sub/2
        ax = {a[3:2], a[0]};  // 2*pool_x + sub%2
        return in_addr_t'(ay * `IMG_W + ax);
    endfunction

    assign anchor_nxt    = anchor + 6'd1;
    assign work_finished = (state == st_finished);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state   <= st_idle;
            phase   <= '0;
            anchor  <= '0;
            rd_en   <= 1'b0;
            rd_addr <= '0;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    phase  <= '0;
                    anchor <= '0;
                    if (en)
                    begin
                        state   <= st_running;
                        rd_en   <= 1'b1;
                        rd_addr <= anchor_base(6'd0);
                    end
                end
                st_running:
                begin
                    if (phase == 3'(`WIN_K - 1))
                    begin
                        rd_en <= 1'b0;  // fifth row out, gap next
                        phase <= phase + 3'd1;
                    end
                    else if (phase == 3'(`ANCHOR_PERIOD - 1))
                    begin
                        phase <= '0;
                        if (anchor == 6'(`ANCHOR_NUM - 1))
                            state <= st_stall;
                        else
                        begin
                            anchor  <= anchor_nxt;
                            rd_en   <= 1'b1;
                            rd_addr <= anchor_base(anchor_nxt);
                        end
                    end
                    else
                    begin
                        rd_addr <= rd_addr + in_addr_t'(`IMG_W);  // next window row
                        phase   <= phase + 3'd1;
                    end
                end
                st_stall:
                begin
                    if (layer_done)
                        state <= st_finished;
                end
                st_finished: state <= st_idle;
                default:     state <= st_idle;
            endcase
        end
    end

    // no read may leak into stall or idle
    assert property (@(posedge clk) disable iff (!rst_n)
        rd_en |-> state == st_running);

endmodule

/* c1s2_pkg.sv */
`include "c1s2_consts.svh"

package c1s2_pkg;

    // pixels, weights, biases and results share one signed word
    typedef logic signed [`PIX_W-1:0] pixel_t;

    // element i is the pixel at rd_addr + i
    typedef pixel_t [`WIN_K-1:0] row_t;

    // tap t = row * WIN_K + col
    typedef pixel_t [`WIN_TAPS-1:0] window_t;

    typedef logic [$clog2(`KERNEL_NUM)-1:0] kidx_t;

    typedef logic [`IN_ADDR_W-1:0]  in_addr_t;
    typedef logic [`OUT_ADDR_W-1:0] out_addr_t;

endpackage

/* c1s2_consts.svh */
`ifndef C1S2_CONSTS_SVH
`define C1S2_CONSTS_SVH

// input image, square
`define IMG_W             12

// convolution window
`define WIN_K             5
`define WIN_TAPS          25   // WIN_K * WIN_K

`define KERNEL_NUM        6

// feature map sides
`define CONV_W            8    // IMG_W - WIN_K + 1
`define POOL_W            4    // CONV_W / 2

`define ANCHOR_NUM        64   // CONV_W * CONV_W
`define ANCHOR_PERIOD     6    // cycles per window, one kernel each

// kernel k lands at k * OUT_KERNEL_OFFSET, power of two
`define OUT_KERNEL_OFFSET 16

`define IN_ADDR_W         8
`define OUT_ADDR_W        8

`define PIX_W             16

`endif
